// ==== vlog.f ====
+incdir+verification
rtl/silver_isa_pkg.sv
rtl/silver_core_pkg.sv
rtl/silver_regfile.sv
rtl/silver_alu.sv
rtl/silver_shifter.sv
rtl/silver_decode_stage.sv
rtl/silver_execute.sv
rtl/silver_core.sv
verification/silver_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module silver_tb -Mdir obj_dir -o silver_sim
./obj_dir/silver_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
   exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0

// ==== verification/silver_ref.svh ====
`ifndef SILVER_REF_SVH
`define SILVER_REF_SVH

logic [31:0] model_regs [64];
logic        model_carry;
logic        model_ovf;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s ^ (s << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// flags move only for add, add with carry and sub
function automatic logic [31:0] alu_ref(input logic [3:0] func, input logic [31:0] a,
                                        input logic [31:0] b);
   logic [32:0] wide;
   logic [63:0] prod;
   logic [31:0] r;
   prod = {32'd0, a} * {32'd0, b};
   wide = {1'b0, a} + {1'b0, b} + {32'd0, (func == 4'd1) ? model_carry : 1'b0};
   case (func)
      4'd0, 4'd1: begin
         r = wide[31:0];
         if (func == 4'd0) model_ovf = (a[31] == b[31]) && (r[31] != a[31]);
         model_carry = wide[32];
      end
      4'd2: begin
         r = a - b;
         model_ovf = (a[31] != b[31]) && (r[31] != a[31]);
      end
      4'd3:    r = {31'd0, model_carry};
      4'd4:    r = {31'd0, model_ovf};
      4'd5:    r = a + 32'd1;
      4'd6:    r = a - 32'd1;
      4'd7:    r = prod[31:0];
      4'd8:    r = prod[63:32];
      4'd9:    r = a & b;
      4'd10:   r = a | b;
      4'd11:   r = a ^ b;
      4'd12:   r = {31'd0, a == b};
      4'd13:   r = {31'd0, $signed(a) < $signed(b)};
      4'd14:   r = {31'd0, a < b};
      default: r = b;
   endcase
   return r;
endfunction

function automatic logic [31:0] shift_ref(input logic [1:0] kind, input logic [31:0] a,
                                          input logic [31:0] b);
   logic [4:0] n;
   n = b[4:0];
   case (kind)
      2'd0:    return (b > 31) ? 32'd0 : a << n;
      2'd1:    return (b > 31) ? 32'd0 : a >> n;
      2'd2:    return (b > 31) ? {32{a[31]}} : 32'($signed(a) >>> n);
      default: return (n == 0) ? a : (a >> n) | (a << (6'd32 - {1'b0, n}));
   endcase
endfunction

// applies one instruction to the model, returns 1 for an Out
function automatic bit ref_step(input logic [31:0] ins, output logic [31:0] out_val);
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] r;
   logic [5:0]  d;
   bit          wr;
   bit          is_out;
   d = ins[30:25];
   a = ins[23] ? {{26{ins[22]}}, ins[22:17]} : model_regs[ins[22:17]];
   b = ins[16] ? {{26{ins[15]}}, ins[15:10]} : model_regs[ins[15:10]];
   wr = 1;
   is_out = 0;
   out_val = '0;
   if (ins[24] && ins[31]) r = ins[23] ? 32'd0 - {9'd0, ins[22:0]} : {9'd0, ins[22:0]};
   else if (ins[24] && ins[23:9] == '0) r = {ins[8:0], model_regs[d][22:0]};
   else if (!ins[24] && !ins[31] && ins[5:0] == 6'd0) r = alu_ref(ins[9:6], a, b);
   else if (!ins[24] && !ins[31] && ins[5:0] == 6'd1) r = shift_ref(ins[7:6], a, b);
   else if (!ins[24] && !ins[31] && ins[5:0] == 6'd6) begin
      r = alu_ref(ins[9:6], a, b);
      is_out = 1;
   end else begin
      r = '0;
      wr = 0; // invalid or dropped
   end
   if (wr) model_regs[d] = r;
   out_val = r;
   return is_out;
endfunction

`endif

// ==== verification/silver_tb.sv ====
`timescale 1ns/100ps

module silver_tb;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        instr_valid;
   logic [31:0] instr;
   logic        out_valid;
   logic [9:0]  data_out;

   logic [31:0] prog_instr [$];
   bit          prog_valid [$];
   bit          prog_out [$];
   logic [31:0] prog_exp [$];
   string       prog_name [$];
   int          due_q [$];
   logic [31:0] exp_q [$];
   string       name_q [$];
   logic [31:0] rnd_state = 32'h17bd;
   int          edge_cnt = 0;
   int          limit = 100000;
   int          error_count = 0;

   `include "silver_ref.svh"

   silver_core #(.out_width(10)) uut (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .out_valid   (out_valid),
      .data_out    (data_out)
   );

   always #50 clk = ~clk;

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         error_count++;
         $display("[ERROR] %s expected %h actual %h", name, exp, act);
         report_failure("value mismatch");
      end
   endtask

   function automatic logic [31:0] next_rand();
      rnd_state = xorshift32(rnd_state);
      return rnd_state;
   endfunction

   function automatic logic [5:0] pick_reg();
      logic [31:0] r;
      r = next_rand();
      return 6'(32'd1 + r % 8);
   endfunction

   function automatic logic [31:0] enc_op(input logic [5:0] opc, input logic [3:0] func,
                                          input logic [5:0] d, input logic a_imm,
                                          input logic [5:0] a, input logic b_imm,
                                          input logic [5:0] b);
      return {1'b0, d, 1'b0, a_imm, a, b_imm, b, func, opc};
   endfunction

   task automatic issue_instr(input string name, input logic [31:0] ins);
      logic [31:0] v;
      bit          o;
      o = ref_step(ins, v);
      prog_instr.push_back(ins);
      prog_valid.push_back(1'b1);
      prog_out.push_back(o);
      prog_exp.push_back({22'd0, v[9:0]});
      prog_name.push_back(name);
   endtask

   task automatic add_gap(input int n);
      for (int i = 0; i < n; i++) begin
         prog_instr.push_back(next_rand()); // junk while not valid
         prog_valid.push_back(1'b0);
         prog_out.push_back(1'b0);
         prog_exp.push_back('0);
         prog_name.push_back("gap");
      end
   endtask

   task automatic out_of(input string name, input logic [5:0] r);
      issue_instr(name, enc_op(6'd6, 4'd15, 6'd63, 1'b0, 6'd0, 1'b0, r));
   endtask

   task automatic build_program();
      logic [31:0] w;
      logic [5:0]  r;
      for (int i = 0; i < 64; i++) model_regs[i] = '0;
      model_carry = 0;
      model_ovf = 0;
      for (int i = 1; i <= 8; i++) begin
         w = next_rand();
         issue_instr("init", {1'b1, 6'(i), 1'b1, w[23], w[22:0]});
         issue_instr("init", {1'b0, 6'(i), 1'b1, 15'd0, w[31:23]}); // load upper right after
      end
      for (int i = 0; i < 64; i++) begin
         r = 6'(9 + i % 8);
         issue_instr("alu", enc_op(6'd0, 4'(i % 16), r, 1'(i % 5 == 0), pick_reg(),
                                   1'b0, pick_reg()));
         out_of("alu", r);
      end
      for (int i = 0; i < 24; i++) begin
         w = next_rand();
         issue_instr("flags", enc_op(6'd0, (w[1:0] == 2'd3) ? 4'd1 : {2'd0, w[1:0]}, 6'd20,
                                     1'b0, pick_reg(), 1'b0, pick_reg()));
         issue_instr("flags", enc_op(6'd6, 4'd3, 6'd21, 1'b0, 6'd0, 1'b0, 6'd0));
         issue_instr("flags", enc_op(6'd6, 4'd4, 6'd22, 1'b0, 6'd0, 1'b0, 6'd0));
      end
      for (int i = 0; i < 32; i++) begin
         w = next_rand();
         issue_instr("shift", {1'b1, 6'd24, 1'b1, 1'b0, 17'd0, w[5:0]}); // amount 0..63
         issue_instr("shift", enc_op(6'd1, 4'(i % 4), 6'd25, 1'b0, pick_reg(), 1'b0, 6'd24));
         out_of("shift", 6'd25);
      end
      for (int g = 0; g < 3; g++) begin
         for (int i = 0; i < 6; i++) begin
            issue_instr("chain", enc_op(6'd0, 4'(i % 3 == 2 ? 7 : i % 3), 6'd30, 1'b0, 6'd30,
                                        1'b0, pick_reg()));
            add_gap(g);
         end
         out_of("chain", 6'd30);
         add_gap(g);
         w = next_rand();
         issue_instr("const", {1'b1, 6'd31, 1'b1, 1'b1, w[22:0]});
         issue_instr("const", {1'b0, 6'd31, 1'b1, 15'd0, w[31:23]});
         out_of("const", 6'd31);
      end
      for (int i = 0; i < 24; i++) begin
         w = next_rand();
         case (i % 3)
            0: w = {1'b0, w[30:25], 1'b0, w[23:6], (w[0] ? 6'(2 + w[2:1]) : 6'(7 + w[5:0] % 57))};
            1: w = {1'b1, w[30:25], 1'b0, w[23:0]};
            default: w = {1'b0, w[30:25], 1'b1, w[23:10], 1'b1, w[8:0]};
         endcase
         issue_instr("invalid", w);
         out_of("invalid", w[30:25]);
      end
   endtask

   // stimulus
   initial begin
      rst_n = 1'b0;
      instr_valid = 1'b0;
      instr = '0;
      build_program();
      limit = prog_instr.size() + 16 + 50;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (6) begin
         @(negedge clk);
         check_value("idle", 32'd0, {22'd0, data_out});
      end
      for (int i = 0; i < prog_instr.size(); i++) begin
         @(posedge clk);
         instr_valid <= prog_valid[i];
         instr <= prog_instr[i];
         if (prog_out[i]) begin
            due_q.push_back(edge_cnt + 4); // issue edge is edge_cnt + 1, out three edges later
            exp_q.push_back(prog_exp[i]);
            name_q.push_back(prog_name[i]);
         end
      end
      @(posedge clk);
      instr_valid <= 1'b0;
      while (due_q.size() != 0) @(negedge clk);
      repeat (3) @(negedge clk);
      if (error_count == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         $display("=== FAIL ===");
         $fatal(1, "checks failed");
      end
   end

   // comparison
   always @(negedge clk) begin
      if (rst_n) begin
         if (out_valid) begin
            if (due_q.size() == 0 || due_q[0] != edge_cnt) begin
               report_failure($sformatf("out_valid came high at cycle %0d with nothing due",
                                        edge_cnt));
            end else begin
               check_value(name_q[0], exp_q[0], {22'd0, data_out});
               void'(due_q.pop_front());
               void'(exp_q.pop_front());
               void'(name_q.pop_front());
            end
         end else if (due_q.size() != 0 && due_q[0] <= edge_cnt) begin
            report_failure($sformatf("out_valid missing for %s at cycle %0d", name_q[0],
                                     edge_cnt));
         end
      end
   end

   always @(posedge clk) begin
      edge_cnt <= edge_cnt + 1;
      if (edge_cnt > limit) report_failure("timeout, the run did not finish in time");
   end

endmodule

// ==== rtl/silver_core.sv ====
`timescale 1ns/100ps

module silver_core #(
   parameter int out_width = 10
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  instr_valid,
   input  silver_isa_pkg::word_t instr,
   output logic                  out_valid,
   output logic [out_width-1:0]  data_out
);

   logic                         dec_valid;
   silver_isa_pkg::word_t        dec_instr;
   silver_core_pkg::ex_payload_t ex_next;
   silver_core_pkg::ex_payload_t ex_q;
   silver_core_pkg::wb_payload_t wb_next;
   silver_core_pkg::wb_payload_t wb_q;
   silver_isa_pkg::reg_idx_t     addr_a;
   silver_isa_pkg::reg_idx_t     addr_b;
   silver_isa_pkg::reg_idx_t     addr_d;
   silver_isa_pkg::word_t        file_a;
   silver_isa_pkg::word_t        file_b;
   silver_isa_pkg::word_t        file_d;

   // decode, execute and writeback registers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dec_valid <= 1'b0;
         dec_instr <= '0;
         ex_q      <= '0;
         wb_q      <= '0;
      end else begin
         dec_valid <= instr_valid;
         dec_instr <= instr;
         ex_q      <= ex_next;
         wb_q      <= wb_next;
      end
   end

   silver_regfile u_regfile (
      .clk     (clk),
      .rst_n   (rst_n),
      .addr_a  (addr_a),
      .addr_b  (addr_b),
      .addr_d  (addr_d),
      .data_a  (file_a),
      .data_b  (file_b),
      .data_d  (file_d),
      .wr_en   (wb_next.valid && wb_next.write), // written as execute retires
      .wr_addr (wb_next.dest),
      .wr_data (wb_next.result)
   );

   silver_decode_stage u_decode (
      .instr_valid (dec_valid),
      .instr       (dec_instr),
      .addr_a      (addr_a),
      .addr_b      (addr_b),
      .addr_d      (addr_d),
      .file_a      (file_a),
      .file_b      (file_b),
      .file_d      (file_d),
      .ex_fwd      (wb_next),
      .ex_payload  (ex_next)
   );

   silver_execute #(
      .out_width (out_width)
   ) u_execute (
      .clk   (clk),
      .rst_n (rst_n),
      .ex    (ex_q),
      .wb    (wb_next)
   );

   assign out_valid = wb_q.valid && wb_q.out;
   assign data_out  = wb_q.result[out_width-1:0];

endmodule

// ==== rtl/silver_execute.sv ====
`timescale 1ns/100ps

module silver_execute #(
   parameter int out_width = 10
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  silver_core_pkg::ex_payload_t ex,
   output silver_core_pkg::wb_payload_t wb
);

   logic                  alu_step;
   silver_isa_pkg::word_t alu_res;
   silver_isa_pkg::word_t shift_res;
   silver_isa_pkg::word_t result;

   if (out_width < 1 || out_width > 32) begin : g_width_check
      $error("out_width must lie between 1 and 32");
   end

   // flags only move for ALU class instructions
   assign alu_step = ex.valid
                   && (ex.opc == silver_isa_pkg::opc_normal || ex.opc == silver_isa_pkg::opc_out);

   silver_alu u_alu (
      .clk   (clk),
      .rst_n (rst_n),
      .step  (alu_step),
      .func  (ex.func),
      .a     (ex.a),
      .b     (ex.b),
      .res   (alu_res)
   );

   silver_shifter u_shifter (
      .kind (silver_isa_pkg::shift_func_t'(ex.func[1:0])),
      .a    (ex.a),
      .b    (ex.b),
      .res  (shift_res)
   );

   always_comb begin
      case (ex.opc)
         silver_isa_pkg::opc_shift:      result = shift_res;
         silver_isa_pkg::opc_load_const: result = ex.const_val;
         silver_isa_pkg::opc_load_upper: result = {ex.const_val[silver_isa_pkg::upc_msb:0],
                                                   ex.d_old[silver_isa_pkg::lc_msb:0]};
         default:                        result = alu_res; // normal, out
      endcase
   end

   always_comb begin
      wb.valid  = ex.valid;
      wb.write  = ex.valid && ex.we;
      wb.dest   = ex.dest;
      wb.result = result;
      wb.out    = ex.valid && ex.opc == silver_isa_pkg::opc_out;
   end

   a_invalid_no_write: assert property (
      @(posedge clk) disable iff (!rst_n)
      (ex.valid && ex.opc == silver_isa_pkg::opc_invalid) |-> !wb.write
   );

endmodule

// ==== rtl/silver_decode_stage.sv ====
`timescale 1ns/100ps

module silver_decode_stage (
   input  logic                          instr_valid,
   input  silver_isa_pkg::word_t         instr,
   output silver_isa_pkg::reg_idx_t      addr_a,
   output silver_isa_pkg::reg_idx_t      addr_b,
   output silver_isa_pkg::reg_idx_t      addr_d,
   input  silver_isa_pkg::word_t         file_a,
   input  silver_isa_pkg::word_t         file_b,
   input  silver_isa_pkg::word_t         file_d,
   input  silver_core_pkg::wb_payload_t  ex_fwd,
   output silver_core_pkg::ex_payload_t  ex_payload
);

   silver_isa_pkg::opc_t  opc;
   silver_isa_pkg::word_t imm_a;
   silver_isa_pkg::word_t imm_b;
   silver_isa_pkg::word_t lc_mag;
   silver_isa_pkg::word_t const_val;
   logic                  fwd_a;
   logic                  fwd_b;
   logic                  fwd_d;

   assign addr_a = instr[silver_isa_pkg::a_msb:silver_isa_pkg::a_lsb];
   assign addr_b = instr[silver_isa_pkg::b_msb:silver_isa_pkg::b_lsb];
   assign addr_d = instr[silver_isa_pkg::d_msb:silver_isa_pkg::d_lsb];

   always_comb begin
      opc = silver_isa_pkg::opc_invalid;
      if (instr[silver_isa_pkg::lc_flag]) begin
         if (instr[silver_isa_pkg::d_imm]) begin
            opc = silver_isa_pkg::opc_load_const;
         end else if (instr[silver_isa_pkg::upc_zero_msb:silver_isa_pkg::upc_zero_lsb] == '0) begin
            opc = silver_isa_pkg::opc_load_upper;
         end
      end else if (!instr[silver_isa_pkg::d_imm]) begin
         // dropped low opcodes fall through as invalid
         case (instr[silver_isa_pkg::opc_msb:silver_isa_pkg::opc_lsb])
            silver_isa_pkg::opc_normal: opc = silver_isa_pkg::opc_normal;
            silver_isa_pkg::opc_shift:  opc = silver_isa_pkg::opc_shift;
            silver_isa_pkg::opc_out:    opc = silver_isa_pkg::opc_out;
            default:                    opc = silver_isa_pkg::opc_invalid;
         endcase
      end
   end

   // 6-bit immediates, sign extended
   assign imm_a = silver_isa_pkg::word_t'(
      $signed(instr[silver_isa_pkg::a_msb:silver_isa_pkg::a_lsb]));
   assign imm_b = silver_isa_pkg::word_t'(
      $signed(instr[silver_isa_pkg::b_msb:silver_isa_pkg::b_lsb]));

   assign lc_mag = silver_isa_pkg::word_t'(instr[silver_isa_pkg::lc_msb:0]);

   always_comb begin
      if (opc == silver_isa_pkg::opc_load_upper) begin
         const_val = silver_isa_pkg::word_t'(instr[silver_isa_pkg::upc_msb:0]);
      end else if (instr[silver_isa_pkg::lc_neg]) begin
         const_val = '0 - lc_mag;
      end else begin
         const_val = lc_mag;
      end
   end

   // bypass from the instruction now in execute
   assign fwd_a = ex_fwd.valid && ex_fwd.write && ex_fwd.dest == addr_a;
   assign fwd_b = ex_fwd.valid && ex_fwd.write && ex_fwd.dest == addr_b;
   assign fwd_d = ex_fwd.valid && ex_fwd.write && ex_fwd.dest == addr_d;

   always_comb begin
      ex_payload.valid = instr_valid;
      ex_payload.opc   = opc;
      ex_payload.func  = silver_isa_pkg::alu_func_t'(
         instr[silver_isa_pkg::func_msb:silver_isa_pkg::func_lsb]);
      ex_payload.dest  = addr_d;
      ex_payload.we    = instr_valid && opc != silver_isa_pkg::opc_invalid;
      if (instr[silver_isa_pkg::a_imm]) begin
         ex_payload.a = imm_a;
      end else begin
         ex_payload.a = fwd_a ? ex_fwd.result : file_a;
      end
      if (instr[silver_isa_pkg::b_imm]) begin
         ex_payload.b = imm_b;
      end else begin
         ex_payload.b = fwd_b ? ex_fwd.result : file_b;
      end
      ex_payload.d_old     = fwd_d ? ex_fwd.result : file_d;
      ex_payload.const_val = const_val;
   end

endmodule

// ==== rtl/silver_shifter.sv ====
`timescale 1ns/100ps

module silver_shifter (
   input  silver_isa_pkg::shift_func_t kind,
   input  silver_isa_pkg::word_t       a,
   input  silver_isa_pkg::word_t       b,
   output silver_isa_pkg::word_t       res
);

   logic [63:0] rot;

   // rotate amount mod 32
   assign rot = {a, a} >> b[4:0];

   always_comb begin
      case (kind)
         silver_isa_pkg::shift_ll: res = a << b;
         silver_isa_pkg::shift_lr: res = a >> b;
         silver_isa_pkg::shift_ar: res = $signed(a) >>> b;
         default:                  res = rot[31:0];
      endcase
   end

endmodule

// ==== rtl/silver_alu.sv ====
`timescale 1ns/100ps

module silver_alu (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      step,
   input  silver_isa_pkg::alu_func_t func,
   input  silver_isa_pkg::word_t     a,
   input  silver_isa_pkg::word_t     b,
   output silver_isa_pkg::word_t     res
);

   logic                  carry_q;
   logic                  overflow_q;
   logic                  carry_d;
   logic                  overflow_d;
   logic [32:0]           sum;
   silver_isa_pkg::word_t diff;
   logic [63:0]           prod;
   logic                  add_ovf;
   logic                  sub_ovf;

   // carry-in only for add with carry
   assign sum = {1'b0, a} + {1'b0, b}
              + ((func == silver_isa_pkg::f_add_carry) ? {32'd0, carry_q} : 33'd0);
   assign diff = a - b;
   assign prod = {32'd0, a} * {32'd0, b};

   assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
   assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

   always_comb begin
      case (func)
         silver_isa_pkg::f_add:       res = sum[31:0];
         silver_isa_pkg::f_add_carry: res = sum[31:0];
         silver_isa_pkg::f_sub:       res = diff;
         silver_isa_pkg::f_carry:     res = {31'd0, carry_q};
         silver_isa_pkg::f_overflow:  res = {31'd0, overflow_q};
         silver_isa_pkg::f_inc:       res = a + 32'd1;
         silver_isa_pkg::f_dec:       res = a - 32'd1;
         silver_isa_pkg::f_mul:       res = prod[31:0];
         silver_isa_pkg::f_mul_hu:    res = prod[63:32];
         silver_isa_pkg::f_and:       res = a & b;
         silver_isa_pkg::f_or:        res = a | b;
         silver_isa_pkg::f_xor:       res = a ^ b;
         silver_isa_pkg::f_equal:     res = {31'd0, a == b};
         silver_isa_pkg::f_less:      res = {31'd0, $signed(a) < $signed(b)};
         silver_isa_pkg::f_lower:     res = {31'd0, a < b};
         default:                     res = b; // f_snd
      endcase
   end

   always_comb begin
      carry_d    = carry_q;
      overflow_d = overflow_q;
      case (func)
         silver_isa_pkg::f_add: begin
            carry_d    = sum[32];
            overflow_d = add_ovf;
         end
         silver_isa_pkg::f_add_carry: begin
            carry_d = sum[32];
         end
         silver_isa_pkg::f_sub: begin
            overflow_d = sub_ovf;
         end
         default: begin
            carry_d = carry_q;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         carry_q    <= 1'b0;
         overflow_q <= 1'b0;
      end else if (step) begin
         carry_q    <= carry_d;
         overflow_q <= overflow_d;
      end
   end

   a_flags_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      !$isunknown({carry_q, overflow_q})
   );

endmodule

// ==== rtl/silver_regfile.sv ====
`timescale 1ns/100ps

module silver_regfile (
   input  logic                     clk,
   input  logic                     rst_n,
   input  silver_isa_pkg::reg_idx_t addr_a,
   input  silver_isa_pkg::reg_idx_t addr_b,
   input  silver_isa_pkg::reg_idx_t addr_d,
   output silver_isa_pkg::word_t    data_a,
   output silver_isa_pkg::word_t    data_b,
   output silver_isa_pkg::word_t    data_d,
   input  logic                     wr_en,
   input  silver_isa_pkg::reg_idx_t wr_addr,
   input  silver_isa_pkg::word_t    wr_data
);

   silver_isa_pkg::word_t regs [64];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 64; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // write-through on all three read ports
   assign data_a = (wr_en && wr_addr == addr_a) ? wr_data : regs[addr_a];
   assign data_b = (wr_en && wr_addr == addr_b) ? wr_data : regs[addr_b];
   assign data_d = (wr_en && wr_addr == addr_d) ? wr_data : regs[addr_d];

   a_wr_data_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      wr_en |-> !$isunknown(wr_data)
   );

endmodule

// ==== rtl/silver_core_pkg.sv ====
package silver_core_pkg;

   // decode -> execute
   typedef struct packed {
      logic                      valid;
      silver_isa_pkg::opc_t      opc;
      silver_isa_pkg::alu_func_t func;
      silver_isa_pkg::reg_idx_t  dest;
      logic                      we;
      silver_isa_pkg::word_t     a;
      silver_isa_pkg::word_t     b;
      silver_isa_pkg::word_t     d_old;     // old dest value for load upper
      silver_isa_pkg::word_t     const_val;
   } ex_payload_t;

   // execute -> writeback, also the forwarding source
   typedef struct packed {
      logic                     valid;
      logic                     write;
      silver_isa_pkg::reg_idx_t dest;
      silver_isa_pkg::word_t    result;
      logic                     out;
   } wb_payload_t;

endpackage

// ==== rtl/silver_isa_pkg.sv ====
package silver_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [5:0]  reg_idx_t;

   // internal opcode, only the classes this core still executes
   typedef enum logic [5:0] {
      opc_normal     = 6'd0,
      opc_shift      = 6'd1,
      opc_out        = 6'd6,
      opc_load_const = 6'd13,
      opc_load_upper = 6'd14,
      opc_invalid    = 6'd15
   } opc_t;

   typedef enum logic [3:0] {
      f_add, f_add_carry, f_sub, f_carry,
      f_overflow, f_inc, f_dec, f_mul,
      f_mul_hu, f_and, f_or, f_xor,
      f_equal, f_less, f_lower, f_snd
   } alu_func_t;

   typedef enum logic [1:0] {
      shift_ll, shift_lr, shift_ar, shift_ror
   } shift_func_t;

   // instruction fields
   localparam int a_msb        = 22;
   localparam int a_lsb        = 17;
   localparam int a_imm        = 23;
   localparam int b_msb        = 15;
   localparam int b_lsb        = 10;
   localparam int b_imm        = 16;
   localparam int d_msb        = 30;
   localparam int d_lsb        = 25;
   localparam int d_imm        = 31;
   localparam int func_msb     = 9;
   localparam int func_lsb     = 6;
   localparam int opc_msb      = 5;
   localparam int opc_lsb      = 0;
   localparam int lc_flag      = 24;
   localparam int lc_neg       = 23;  // negate the load constant
   localparam int lc_msb       = 22;
   localparam int upc_msb      = 8;
   localparam int upc_zero_msb = 23; // must be zero for load upper
   localparam int upc_zero_lsb = 9;

endpackage
